//--- verilog/hb_pkg.sv
// HyperBus shared front end package
// Widths, reset values and the stream and register bus types
// shared by the chip-rule registers, decoder, arbiter and PHY mux
package hb_pkg;

    localparam int unsigned NUM_PHYS     = 2;
    localparam int unsigned NUM_CHIPS    = 2;
    localparam int unsigned PHY_DATA_W   = 16 * NUM_PHYS;
    localparam int unsigned PHY_STRB_W   = 2 * NUM_PHYS;
    localparam int unsigned HYPER_ADDR_W = 32;
    localparam int unsigned BURST_W      = 8;
    localparam int unsigned REG_ADDR_W   = 10;
    localparam int unsigned REG_DATA_W   = 32;
    localparam int unsigned REG_SEL_BIT  = 8;
    // Word index bits between byte offset and pad select
    localparam int unsigned REG_WORD_W   = REG_SEL_BIT - 2;

    typedef logic [HYPER_ADDR_W-1:0] addr_t;
    typedef logic [REG_WORD_W-1:0]   reg_word_t;

    localparam addr_t RST_CHIP_BASE  = 'h0;
    // 64 KiB per chip
    localparam addr_t RST_CHIP_SPACE = 'h1_0000;

    localparam int unsigned CHIP_BASE_OFFS  = 0;
    localparam int unsigned CHIP_SPACE_OFFS = 1;

    typedef struct packed {
        addr_t              addr;
        logic               write;
        logic [BURST_W-1:0] burst;
    } hyper_tf_t;

    typedef struct packed {
        hyper_tf_t            trans;
        logic [NUM_CHIPS-1:0] cs;
    } tf_t;

    typedef struct packed {
        logic [PHY_DATA_W-1:0] data;
        logic                  last;
        logic [PHY_STRB_W-1:0] strb;
    } hyper_tx_t;

    typedef struct packed {
        logic [PHY_DATA_W-1:0] data;
        logic                  last;
        logic                  error;
    } hyper_rx_t;

    typedef struct packed {
        addr_t base;
        addr_t space;
    } chip_rule_t;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [REG_ADDR_W-1:0] addr;
        logic [REG_DATA_W-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic                  ready;
        logic                  error;
        logic [REG_DATA_W-1:0] rdata;
    } reg_rsp_t;

endpackage

//--- verilog/hb_cfg_regs.sv
// HyperBus chip-rule register file
// Base and space registers per chip on the register bus. The bus is
// answered in the same cycle; pad-register and unmapped addresses give
// an error, and writes are refused while a transaction is in flight
module hb_cfg_regs (
    input  logic                                     clk_phy_i,
    input  logic                                     rst_n_i,
    input  hb_pkg::reg_req_t                         reg_req_i,
    output hb_pkg::reg_rsp_t                         reg_rsp_o,
    input  logic                                     busy_i,
    output hb_pkg::chip_rule_t [hb_pkg::NUM_CHIPS-1:0] chip_rules_o
);

    hb_pkg::chip_rule_t [hb_pkg::NUM_CHIPS-1:0] rules_q;

    hb_pkg::reg_word_t            word_idx;
    logic [hb_pkg::NUM_CHIPS-1:0] base_hit;
    logic [hb_pkg::NUM_CHIPS-1:0] space_hit;
    hb_pkg::addr_t                rd_value;
    logic                         pad_sel;
    logic                         above_map;
    logic                         mapped;
    logic                         refused;
    logic                         err;
    logic                         wr_en;

    assign word_idx  = reg_req_i.addr[hb_pkg::REG_SEL_BIT-1:2];
    assign pad_sel   = reg_req_i.addr[hb_pkg::REG_SEL_BIT];
    assign above_map = |reg_req_i.addr[hb_pkg::REG_ADDR_W-1:hb_pkg::REG_SEL_BIT+1];

    always_comb begin
        base_hit  = '0;
        space_hit = '0;
        rd_value  = '0;
        for (int i = 0; i < hb_pkg::NUM_CHIPS; i++) begin
            if (word_idx == hb_pkg::reg_word_t'(2 * i + hb_pkg::CHIP_BASE_OFFS)) begin
                base_hit[i] = 1'b1;
                rd_value    = rules_q[i].base;
            end
            if (word_idx == hb_pkg::reg_word_t'(2 * i + hb_pkg::CHIP_SPACE_OFFS)) begin
                space_hit[i] = 1'b1;
                rd_value     = rules_q[i].space;
            end
        end
    end

    assign mapped  = (|base_hit | |space_hit) & ~pad_sel & ~above_map;
    // Chip map must not move under an active transfer
    assign refused = reg_req_i.write & busy_i;
    assign err     = reg_req_i.valid & (~mapped | refused);
    assign wr_en   = reg_req_i.valid & reg_req_i.write & ~err;

    assign reg_rsp_o.ready = reg_req_i.valid;
    assign reg_rsp_o.error = err;
    assign reg_rsp_o.rdata = (reg_req_i.valid & mapped & ~reg_req_i.write) ? rd_value : '0;

    always_ff @(posedge clk_phy_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < hb_pkg::NUM_CHIPS; i++) begin
                rules_q[i].base  <= hb_pkg::RST_CHIP_BASE
                                  + hb_pkg::addr_t'(i) * hb_pkg::RST_CHIP_SPACE;
                rules_q[i].space <= hb_pkg::RST_CHIP_SPACE;
            end
        end else if (wr_en) begin
            for (int i = 0; i < hb_pkg::NUM_CHIPS; i++) begin
                if (base_hit[i]) begin
                    rules_q[i].base <= reg_req_i.wdata;
                end
                if (space_hit[i]) begin
                    rules_q[i].space <= reg_req_i.wdata;
                end
            end
        end
    end

    assign chip_rules_o = rules_q;

endmodule

//--- verilog/hb_chip_decode.sv
// HyperBus chip-select decoder
// Maps an AXI-side transaction address onto a one-hot chip select and
// a chip-relative address using the chip rules. Unmatched addresses
// fall back to chip 0
module hb_chip_decode (
    input  hb_pkg::hyper_tf_t                          axi_trans_i,
    input  hb_pkg::chip_rule_t [hb_pkg::NUM_CHIPS-1:0] chip_rules_i,
    output hb_pkg::tf_t                                tf_o
);

    logic                          match;
    logic [hb_pkg::NUM_CHIPS-1:0]  cs;
    hb_pkg::addr_t                 base;
    logic [hb_pkg::HYPER_ADDR_W:0] limit;

    always_comb begin
        match = 1'b0;
        cs    = '0;
        cs[0] = 1'b1;
        base  = chip_rules_i[0].base;
        limit = '0;
        // Lowest index wins on overlap
        for (int i = 0; i < hb_pkg::NUM_CHIPS; i++) begin
            limit = {1'b0, chip_rules_i[i].base} + {1'b0, chip_rules_i[i].space};
            if (!match && axi_trans_i.addr >= chip_rules_i[i].base
                    && {1'b0, axi_trans_i.addr} < limit) begin
                match = 1'b1;
                cs    = '0;
                cs[i] = 1'b1;
                base  = chip_rules_i[i].base;
            end
        end
    end

    always_comb begin
        tf_o            = '0;
        tf_o.trans      = axi_trans_i;
        tf_o.trans.addr = axi_trans_i.addr - base;
        tf_o.cs         = cs;
    end

endmodule

//--- verilog/hb_arbiter.sv
// HyperBus PHY arbiter
// Grants the PHY to either the AXI or the uDMA master and keeps the
// grant until the read's last beat or the write's response is through.
// Ties alternate, starting with AXI after reset
module hb_arbiter (
    input  logic clk_phy_i,
    input  logic rst_n_i,
    input  logic axi_req_i,
    input  logic udma_req_i,
    input  logic trans_done_i,
    input  logic trans_write_i,
    input  logic tx_last_done_i,
    input  logic rx_last_done_i,
    input  logic b_done_i,
    output logic sel_o,
    output logic open_o,
    output logic busy_o
);

    typedef enum logic [2:0] {
        IDLE,
        GRANT,
        BUSY_RX,
        BUSY_TX,
        WAIT_B
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   sel_q;
    logic   sel_d;
    logic   last_udma_q;
    logic   last_udma_d;
    logic   pick_udma;

    // uDMA wins alone, or on a tie when AXI won last
    assign pick_udma = udma_req_i & (~axi_req_i | ~last_udma_q);

    always_comb begin
        state_d     = state_q;
        sel_d       = sel_q;
        last_udma_d = last_udma_q;
        unique case (state_q)
            IDLE: begin
                if (axi_req_i || udma_req_i) begin
                    state_d     = GRANT;
                    sel_d       = pick_udma;
                    last_udma_d = pick_udma;
                end
            end
            GRANT: begin
                if (trans_done_i) begin
                    state_d = trans_write_i ? BUSY_TX : BUSY_RX;
                end
            end
            BUSY_RX: begin
                if (rx_last_done_i) begin
                    state_d = IDLE;
                end
            end
            BUSY_TX: begin
                if (tx_last_done_i) begin
                    state_d = WAIT_B;
                end
            end
            WAIT_B: begin
                if (b_done_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_phy_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            sel_q       <= 1'b0;
            last_udma_q <= 1'b1;
        end else begin
            state_q     <= state_d;
            sel_q       <= sel_d;
            last_udma_q <= last_udma_d;
        end
    end

    assign sel_o  = sel_q;
    assign open_o = (state_q == GRANT);
    assign busy_o = (state_q != IDLE);

endmodule

//--- verilog/hb_phy_mux.sv
// HyperBus PHY stream mux
// Steers trans, tx, rx and b between the PHY and the granted master,
// and reports the handshake events the arbiter tracks
module hb_phy_mux (
    input  logic              sel_i,
    input  logic              open_i,
    // AXI side, already decoded
    input  hb_pkg::tf_t       axi_trans_i,
    input  logic              axi_trans_valid_i,
    output logic              axi_trans_ready_o,
    input  hb_pkg::hyper_tx_t axi_tx_i,
    input  logic              axi_tx_valid_i,
    output logic              axi_tx_ready_o,
    output hb_pkg::hyper_rx_t axi_rx_o,
    output logic              axi_rx_valid_o,
    input  logic              axi_rx_ready_i,
    output logic              axi_b_error_o,
    output logic              axi_b_valid_o,
    input  logic              axi_b_ready_i,
    // uDMA side
    input  hb_pkg::tf_t       udma_trans_i,
    input  logic              udma_trans_valid_i,
    output logic              udma_trans_ready_o,
    input  hb_pkg::hyper_tx_t udma_tx_i,
    input  logic              udma_tx_valid_i,
    output logic              udma_tx_ready_o,
    output hb_pkg::hyper_rx_t udma_rx_o,
    output logic              udma_rx_valid_o,
    input  logic              udma_rx_ready_i,
    // PHY side
    output hb_pkg::tf_t       phy_trans_o,
    output logic              phy_trans_valid_o,
    input  logic              phy_trans_ready_i,
    output hb_pkg::hyper_tx_t phy_tx_o,
    output logic              phy_tx_valid_o,
    input  logic              phy_tx_ready_i,
    input  hb_pkg::hyper_rx_t phy_rx_i,
    input  logic              phy_rx_valid_i,
    output logic              phy_rx_ready_o,
    input  logic              phy_b_error_i,
    input  logic              phy_b_valid_i,
    output logic              phy_b_ready_o,
    // Events for the arbiter
    output logic              trans_done_o,
    output logic              trans_write_o,
    output logic              tx_last_done_o,
    output logic              rx_last_done_o,
    output logic              b_done_o
);

    // Transaction only passes in the grant cycle window
    assign phy_trans_o        = sel_i ? udma_trans_i : axi_trans_i;
    assign phy_trans_valid_o  = open_i & (sel_i ? udma_trans_valid_i : axi_trans_valid_i);
    assign axi_trans_ready_o  = open_i & ~sel_i & phy_trans_ready_i;
    assign udma_trans_ready_o = open_i & sel_i & phy_trans_ready_i;

    assign phy_tx_o        = sel_i ? udma_tx_i : axi_tx_i;
    assign phy_tx_valid_o  = sel_i ? udma_tx_valid_i : axi_tx_valid_i;
    assign axi_tx_ready_o  = ~sel_i & phy_tx_ready_i;
    assign udma_tx_ready_o = sel_i & phy_tx_ready_i;

    assign axi_rx_o        = phy_rx_i;
    assign udma_rx_o       = phy_rx_i;
    assign axi_rx_valid_o  = ~sel_i & phy_rx_valid_i;
    assign udma_rx_valid_o = sel_i & phy_rx_valid_i;
    assign phy_rx_ready_o  = sel_i ? udma_rx_ready_i : axi_rx_ready_i;

    // uDMA has no b channel, so its responses are swallowed here
    assign axi_b_error_o = ~sel_i & phy_b_error_i;
    assign axi_b_valid_o = ~sel_i & phy_b_valid_i;
    assign phy_b_ready_o = sel_i | axi_b_ready_i;

    assign trans_done_o   = phy_trans_valid_o & phy_trans_ready_i;
    assign trans_write_o  = phy_trans_o.trans.write;
    assign tx_last_done_o = phy_tx_valid_o & phy_tx_ready_i & phy_tx_o.last;
    assign rx_last_done_o = phy_rx_valid_i & phy_rx_ready_o & phy_rx_i.last;
    assign b_done_o       = phy_b_valid_i & phy_b_ready_o;

endmodule

//--- verilog/hyperbus_share_top.sv
// Shared HyperBus PHY front end
// Joins the AXI-side and uDMA-side transaction streams onto one PHY:
// chip-rule registers, AXI chip-select decode, grant arbiter and the
// stream mux, all on the PHY clock
module hyperbus_share_top (
    input  logic              clk_phy_i,
    input  logic              rst_n_i,
    // Register bus
    input  hb_pkg::reg_req_t  reg_req_i,
    output hb_pkg::reg_rsp_t  reg_rsp_o,
    // AXI side
    input  hb_pkg::hyper_tf_t axi_trans_i,
    input  logic              axi_trans_valid_i,
    output logic              axi_trans_ready_o,
    input  hb_pkg::hyper_tx_t axi_tx_i,
    input  logic              axi_tx_valid_i,
    output logic              axi_tx_ready_o,
    output hb_pkg::hyper_rx_t axi_rx_o,
    output logic              axi_rx_valid_o,
    input  logic              axi_rx_ready_i,
    output logic              axi_b_error_o,
    output logic              axi_b_valid_o,
    input  logic              axi_b_ready_i,
    // uDMA side
    input  hb_pkg::tf_t       udma_trans_i,
    input  logic              udma_trans_valid_i,
    output logic              udma_trans_ready_o,
    input  hb_pkg::hyper_tx_t udma_tx_i,
    input  logic              udma_tx_valid_i,
    output logic              udma_tx_ready_o,
    output hb_pkg::hyper_rx_t udma_rx_o,
    output logic              udma_rx_valid_o,
    input  logic              udma_rx_ready_i,
    // PHY side
    output hb_pkg::tf_t       phy_trans_o,
    output logic              phy_trans_valid_o,
    input  logic              phy_trans_ready_i,
    output hb_pkg::hyper_tx_t phy_tx_o,
    output logic              phy_tx_valid_o,
    input  logic              phy_tx_ready_i,
    input  hb_pkg::hyper_rx_t phy_rx_i,
    input  logic              phy_rx_valid_i,
    output logic              phy_rx_ready_o,
    input  logic              phy_b_error_i,
    input  logic              phy_b_valid_i,
    output logic              phy_b_ready_o
);

    hb_pkg::chip_rule_t [hb_pkg::NUM_CHIPS-1:0] chip_rules;
    hb_pkg::tf_t                                axi_tf;

    logic sel;
    logic grant_open;
    logic busy;
    logic trans_done;
    logic trans_write;
    logic tx_last_done;
    logic rx_last_done;
    logic b_done;

    hb_cfg_regs u_cfg_regs (
        .clk_phy_i    ( clk_phy_i  ),
        .rst_n_i      ( rst_n_i    ),
        .reg_req_i    ( reg_req_i  ),
        .reg_rsp_o    ( reg_rsp_o  ),
        .busy_i       ( busy       ),
        .chip_rules_o ( chip_rules )
    );

    hb_chip_decode u_chip_decode (
        .axi_trans_i  ( axi_trans_i ),
        .chip_rules_i ( chip_rules  ),
        .tf_o         ( axi_tf      )
    );

    hb_arbiter u_arbiter (
        .clk_phy_i      ( clk_phy_i          ),
        .rst_n_i        ( rst_n_i            ),
        .axi_req_i      ( axi_trans_valid_i  ),
        .udma_req_i     ( udma_trans_valid_i ),
        .trans_done_i   ( trans_done         ),
        .trans_write_i  ( trans_write        ),
        .tx_last_done_i ( tx_last_done       ),
        .rx_last_done_i ( rx_last_done       ),
        .b_done_i       ( b_done             ),
        .sel_o          ( sel                ),
        .open_o         ( grant_open         ),
        .busy_o         ( busy               )
    );

    hb_phy_mux u_phy_mux (
        .sel_i              ( sel                ),
        .open_i             ( grant_open         ),
        .axi_trans_i        ( axi_tf             ),
        .axi_trans_valid_i  ( axi_trans_valid_i  ),
        .axi_trans_ready_o  ( axi_trans_ready_o  ),
        .axi_tx_i           ( axi_tx_i           ),
        .axi_tx_valid_i     ( axi_tx_valid_i     ),
        .axi_tx_ready_o     ( axi_tx_ready_o     ),
        .axi_rx_o           ( axi_rx_o           ),
        .axi_rx_valid_o     ( axi_rx_valid_o     ),
        .axi_rx_ready_i     ( axi_rx_ready_i     ),
        .axi_b_error_o      ( axi_b_error_o      ),
        .axi_b_valid_o      ( axi_b_valid_o      ),
        .axi_b_ready_i      ( axi_b_ready_i      ),
        .udma_trans_i       ( udma_trans_i       ),
        .udma_trans_valid_i ( udma_trans_valid_i ),
        .udma_trans_ready_o ( udma_trans_ready_o ),
        .udma_tx_i          ( udma_tx_i          ),
        .udma_tx_valid_i    ( udma_tx_valid_i    ),
        .udma_tx_ready_o    ( udma_tx_ready_o    ),
        .udma_rx_o          ( udma_rx_o          ),
        .udma_rx_valid_o    ( udma_rx_valid_o    ),
        .udma_rx_ready_i    ( udma_rx_ready_i    ),
        .phy_trans_o        ( phy_trans_o        ),
        .phy_trans_valid_o  ( phy_trans_valid_o  ),
        .phy_trans_ready_i  ( phy_trans_ready_i  ),
        .phy_tx_o           ( phy_tx_o           ),
        .phy_tx_valid_o     ( phy_tx_valid_o     ),
        .phy_tx_ready_i     ( phy_tx_ready_i     ),
        .phy_rx_i           ( phy_rx_i           ),
        .phy_rx_valid_i     ( phy_rx_valid_i     ),
        .phy_rx_ready_o     ( phy_rx_ready_o     ),
        .phy_b_error_i      ( phy_b_error_i      ),
        .phy_b_valid_i      ( phy_b_valid_i      ),
        .phy_b_ready_o      ( phy_b_ready_o      ),
        .trans_done_o       ( trans_done         ),
        .trans_write_o      ( trans_write        ),
        .tx_last_done_o     ( tx_last_done       ),
        .rx_last_done_o     ( rx_last_done       ),
        .b_done_o           ( b_done             )
    );

endmodule

//--- testbench/hyperbus_share_asserts.sv
// Stream rule checks for the shared HyperBus front end
// Bound into the top level; watches the PHY trans stream hold rule,
// rx routing exclusivity and b routing while the uDMA is granted
module hyperbus_share_asserts (
    input logic        clk_phy_i,
    input logic        rst_n_i,
    input hb_pkg::tf_t phy_trans_o,
    input logic        phy_trans_valid_o,
    input logic        phy_trans_ready_i,
    input logic        axi_rx_valid_o,
    input logic        udma_rx_valid_o,
    input logic        axi_b_valid_o,
    input logic        sel
);

    timeunit 1ns;
    timeprecision 100ps;

    // Pending trans must hold valid and data
    trans_hold: assert property (@(posedge clk_phy_i) disable iff (!rst_n_i)
        phy_trans_valid_o && !phy_trans_ready_i |=> phy_trans_valid_o && $stable(phy_trans_o))
        else $error("phy trans dropped or changed before handshake");

    rx_exclusive: assert property (@(posedge clk_phy_i) disable iff (!rst_n_i)
        !(axi_rx_valid_o && udma_rx_valid_o))
        else $error("rx valid routed to both masters");

    b_not_udma: assert property (@(posedge clk_phy_i) disable iff (!rst_n_i)
        $rose(axi_b_valid_o) |-> !sel)
        else $error("AXI b valid rose during a uDMA grant");

endmodule

bind hyperbus_share_top hyperbus_share_asserts u_asserts (
    .clk_phy_i         ( clk_phy_i         ),
    .rst_n_i           ( rst_n_i           ),
    .phy_trans_o       ( phy_trans_o       ),
    .phy_trans_valid_o ( phy_trans_valid_o ),
    .phy_trans_ready_i ( phy_trans_ready_i ),
    .axi_rx_valid_o    ( axi_rx_valid_o    ),
    .udma_rx_valid_o   ( udma_rx_valid_o   ),
    .axi_b_valid_o     ( axi_b_valid_o     ),
    .sel               ( sel               )
);

//--- testbench/tb_hyperbus_share.sv
// Testbench for the shared HyperBus front end
// Drives both masters, the register bus and a simple PHY model,
// and checks grants, routing and the chip-rule registers
module tb_hyperbus_share;

    timeunit 1ns;
    timeprecision 100ps;

    // Six short tests of well under 100 cycles each, with wide margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic clk_phy_i = 1'b0;
    logic rst_n_i;
    hb_pkg::reg_req_t  reg_req_i;
    hb_pkg::reg_rsp_t  reg_rsp_o;
    hb_pkg::hyper_tf_t axi_trans_i;
    logic axi_trans_valid_i, axi_trans_ready_o;
    hb_pkg::hyper_tx_t axi_tx_i;
    logic axi_tx_valid_i, axi_tx_ready_o;
    hb_pkg::hyper_rx_t axi_rx_o;
    logic axi_rx_valid_o, axi_rx_ready_i;
    logic axi_b_error_o, axi_b_valid_o, axi_b_ready_i;
    hb_pkg::tf_t       udma_trans_i;
    logic udma_trans_valid_i, udma_trans_ready_o;
    hb_pkg::hyper_tx_t udma_tx_i;
    logic udma_tx_valid_i, udma_tx_ready_o;
    hb_pkg::hyper_rx_t udma_rx_o;
    logic udma_rx_valid_o, udma_rx_ready_i;
    hb_pkg::tf_t       phy_trans_o;
    logic phy_trans_valid_o, phy_trans_ready_i;
    hb_pkg::hyper_tx_t phy_tx_o;
    logic phy_tx_valid_o, phy_tx_ready_i;
    hb_pkg::hyper_rx_t phy_rx_i;
    logic phy_rx_valid_i, phy_rx_ready_o;
    logic phy_b_error_i, phy_b_valid_i, phy_b_ready_o;

    integer seed = 32'h1142_9ef3;
    int errors = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    int cycles = 0;

    hyperbus_share_top u_hyperbus_share_top (.*);

    always #20 clk_phy_i = ~clk_phy_i;

    always @(posedge clk_phy_i) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_tf(string name, hb_pkg::tf_t exp, hb_pkg::tf_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_tx(string name, hb_pkg::hyper_tx_t exp, hb_pkg::hyper_tx_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_rx(string name, hb_pkg::hyper_rx_t exp, hb_pkg::hyper_rx_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_rsp(string name, hb_pkg::reg_rsp_t exp, hb_pkg::reg_rsp_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic finish_test(string name, int errors_before);
        if (errors == errors_before) begin
            $display("%s: ok", name);
            tests_ok++;
        end else begin
            $display("%s: FAILED with %0d errors", name, errors - errors_before);
            tests_bad++;
        end
    endtask

    // One register access; the response is combinational in the same cycle
    task automatic reg_access(logic wr, int addr, int wdata, logic exp_err, int exp_rdata);
        hb_pkg::reg_rsp_t exp;
        @(negedge clk_phy_i);
        reg_req_i = '{valid: 1'b1, write: wr, addr: addr[9:0], wdata: wdata};
        #5;
        exp = '{ready: 1'b1, error: exp_err, rdata: exp_rdata};
        check_rsp("reg_rsp_o", exp, reg_rsp_o);
        @(negedge clk_phy_i);
        reg_req_i = '0;
    endtask

    // PHY model accepts one transaction, then the winning master drops valid
    task automatic phy_accept(hb_pkg::tf_t exp, logic from_udma);
        do begin
            @(negedge clk_phy_i);
        end while (!phy_trans_valid_o);
        check_tf("phy_trans_o", exp, phy_trans_o);
        phy_trans_ready_i = 1'b1;
        #5;
        check_bit("axi_trans_ready_o", !from_udma, axi_trans_ready_o);
        check_bit("udma_trans_ready_o", from_udma, udma_trans_ready_o);
        @(negedge clk_phy_i);
        phy_trans_ready_i = 1'b0;
        if (from_udma) begin
            udma_trans_valid_i = 1'b0;
        end else begin
            axi_trans_valid_i = 1'b0;
        end
    endtask

    // PHY model returns read beats with random data
    task automatic phy_read(int burst, logic to_udma);
        hb_pkg::hyper_rx_t beat;
        axi_rx_ready_i  = !to_udma;
        udma_rx_ready_i = to_udma;
        for (int i = 0; i < burst; i++) begin
            beat.data  = $random(seed);
            beat.last  = (i == burst - 1);
            beat.error = 1'b0;
            phy_rx_i       = beat;
            phy_rx_valid_i = 1'b1;
            #5;
            check_rx(to_udma ? "udma_rx_o" : "axi_rx_o", beat, to_udma ? udma_rx_o : axi_rx_o);
            check_bit("axi_rx_valid_o", !to_udma, axi_rx_valid_o);
            check_bit("udma_rx_valid_o", to_udma, udma_rx_valid_o);
            check_bit("phy_rx_ready_o", 1'b1, phy_rx_ready_o);
            check_bit("phy_trans_valid_o", 1'b0, phy_trans_valid_o);
            @(negedge clk_phy_i);
        end
        phy_rx_valid_i = 1'b0;
    endtask

    // Master sends write beats; the PHY model sinks them
    task automatic master_write(int burst, logic from_udma);
        hb_pkg::hyper_tx_t beat;
        phy_tx_ready_i = 1'b1;
        for (int i = 0; i < burst; i++) begin
            beat.data = $random(seed);
            beat.last = (i == burst - 1);
            beat.strb = 4'hf;
            if (from_udma) begin
                udma_tx_i       = beat;
                udma_tx_valid_i = 1'b1;
            end else begin
                axi_tx_i       = beat;
                axi_tx_valid_i = 1'b1;
            end
            #5;
            check_tx("phy_tx_o", beat, phy_tx_o);
            check_bit("phy_tx_valid_o", 1'b1, phy_tx_valid_o);
            check_bit("axi_tx_ready_o", !from_udma, axi_tx_ready_o);
            check_bit("udma_tx_ready_o", from_udma, udma_tx_ready_o);
            check_bit("phy_trans_valid_o", 1'b0, phy_trans_valid_o);
            @(negedge clk_phy_i);
        end
        udma_tx_valid_i = 1'b0;
        axi_tx_valid_i  = 1'b0;
        phy_tx_ready_i  = 1'b0;
    endtask

    // PHY model raises b once
    task automatic phy_b(logic to_udma, logic err);
        axi_b_ready_i = !to_udma;
        phy_b_error_i = err;
        phy_b_valid_i = 1'b1;
        #5;
        check_bit("axi_b_valid_o", !to_udma, axi_b_valid_o);
        if (!to_udma) begin
            check_bit("axi_b_error_o", err, axi_b_error_o);
        end
        check_bit("phy_b_ready_o", 1'b1, phy_b_ready_o);
        check_bit("phy_trans_valid_o", 1'b0, phy_trans_valid_o);
        @(negedge clk_phy_i);
        phy_b_valid_i = 1'b0;
        phy_b_error_i = 1'b0;
        axi_b_ready_i = 1'b0;
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = errors;
        check_bit("phy_trans_valid_o", 1'b0, phy_trans_valid_o);
        check_bit("phy_tx_valid_o", 1'b0, phy_tx_valid_o);
        check_bit("axi_rx_valid_o", 1'b0, axi_rx_valid_o);
        check_bit("udma_rx_valid_o", 1'b0, udma_rx_valid_o);
        check_bit("axi_b_valid_o", 1'b0, axi_b_valid_o);
        check_bit("phy_b_ready_o", 1'b0, phy_b_ready_o);
        reg_access(1'b0, 'h00, 0, 1'b0, 'h0);
        reg_access(1'b0, 'h04, 0, 1'b0, 'h1_0000);
        reg_access(1'b0, 'h08, 0, 1'b0, 'h1_0000);
        reg_access(1'b0, 'h0c, 0, 1'b0, 'h1_0000);
        reg_access(1'b0, 'h100, 0, 1'b1, 'h0);
        finish_test("reset state", e0);
    endtask

    task automatic test_axi_read();
        int e0;
        e0 = errors;
        @(negedge clk_phy_i);
        axi_trans_i       = '{addr: 32'h1_0040, write: 1'b0, burst: 8'd4};
        axi_trans_valid_i = 1'b1;
        phy_accept('{trans: '{addr: 32'h40, write: 1'b0, burst: 8'd4}, cs: 2'b10}, 1'b0);
        phy_read(4, 1'b0);
        finish_test("axi read", e0);
    endtask

    task automatic test_udma_write();
        int e0;
        hb_pkg::tf_t tf;
        e0 = errors;
        tf = '{trans: '{addr: 32'h200, write: 1'b1, burst: 8'd3}, cs: 2'b01};
        @(negedge clk_phy_i);
        udma_trans_i       = tf;
        udma_trans_valid_i = 1'b1;
        phy_accept(tf, 1'b1);
        master_write(3, 1'b1);
        phy_b(1'b1, 1'b0);
        finish_test("udma write", e0);
    endtask

    task automatic test_udma_read();
        int e0;
        hb_pkg::tf_t tf;
        e0 = errors;
        tf = '{trans: '{addr: 32'h400, write: 1'b0, burst: 8'd2}, cs: 2'b10};
        @(negedge clk_phy_i);
        udma_trans_i       = tf;
        udma_trans_valid_i = 1'b1;
        phy_accept(tf, 1'b1);
        phy_read(2, 1'b1);
        finish_test("udma read", e0);
    endtask

    task automatic test_tie_hold();
        int e0;
        hb_pkg::tf_t utf;
        e0 = errors;
        utf = '{trans: '{addr: 32'h300, write: 1'b1, burst: 8'd2}, cs: 2'b10};
        @(negedge clk_phy_i);
        axi_trans_i        = '{addr: 32'h80, write: 1'b1, burst: 8'd2};
        axi_trans_valid_i  = 1'b1;
        udma_trans_i       = utf;
        udma_trans_valid_i = 1'b1;
        phy_accept('{trans: '{addr: 32'h80, write: 1'b1, burst: 8'd2}, cs: 2'b01}, 1'b0);
        check_bit("udma_trans_ready_o", 1'b0, udma_trans_ready_o);
        master_write(2, 1'b0);
        phy_b(1'b0, 1'b1);
        phy_accept(utf, 1'b1);
        master_write(2, 1'b1);
        phy_b(1'b1, 1'b0);
        finish_test("tie and hold", e0);
    endtask

    task automatic test_reg_rules();
        int e0;
        e0 = errors;
        @(negedge clk_phy_i);
        axi_trans_i       = '{addr: 32'h40, write: 1'b0, burst: 8'd2};
        axi_trans_valid_i = 1'b1;
        phy_accept('{trans: '{addr: 32'h40, write: 1'b0, burst: 8'd2}, cs: 2'b01}, 1'b0);
        // Arbiter is busy until the read's last beat
        reg_access(1'b1, 'h08, 'h2_0000, 1'b1, 'h0);
        phy_read(2, 1'b0);
        reg_access(1'b0, 'h08, 0, 1'b0, 'h1_0000);
        reg_access(1'b1, 'h08, 'h2_0000, 1'b0, 'h0);
        reg_access(1'b0, 'h08, 0, 1'b0, 'h2_0000);
        // Chip 0 now spans 0x100 up to 0x1_0100
        reg_access(1'b1, 'h00, 'h100, 1'b0, 'h0);
        @(negedge clk_phy_i);
        axi_trans_i       = '{addr: 32'h1_8000, write: 1'b0, burst: 8'd1};
        axi_trans_valid_i = 1'b1;
        phy_accept('{trans: '{addr: 32'h1_7f00, write: 1'b0, burst: 8'd1}, cs: 2'b01}, 1'b0);
        phy_read(1, 1'b0);
        finish_test("register rules", e0);
    endtask

    initial begin
        rst_n_i            = 1'b0;
        reg_req_i          = '0;
        axi_trans_i        = '0;
        axi_trans_valid_i  = 1'b0;
        axi_tx_i           = '0;
        axi_tx_valid_i     = 1'b0;
        axi_rx_ready_i     = 1'b0;
        axi_b_ready_i      = 1'b0;
        udma_trans_i       = '0;
        udma_trans_valid_i = 1'b0;
        udma_tx_i          = '0;
        udma_tx_valid_i    = 1'b0;
        udma_rx_ready_i    = 1'b0;
        phy_trans_ready_i  = 1'b0;
        phy_tx_ready_i     = 1'b0;
        phy_rx_i           = '0;
        phy_rx_valid_i     = 1'b0;
        phy_b_error_i      = 1'b0;
        phy_b_valid_i      = 1'b0;
        repeat (5) @(posedge clk_phy_i);
        @(negedge clk_phy_i);
        rst_n_i = 1'b1;
        #5;
        test_reset_state();
        test_axi_read();
        test_udma_write();
        test_udma_read();
        test_tie_hold();
        test_reg_rules();
        $display("Tests passed %0d, failed %0d, check errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- sim.f
verilog/hb_pkg.sv
verilog/hb_cfg_regs.sv
verilog/hb_chip_decode.sv
verilog/hb_arbiter.sv
verilog/hb_phy_mux.sv
verilog/hyperbus_share_top.sv
testbench/hyperbus_share_asserts.sv
testbench/tb_hyperbus_share.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_hyperbus_share \
    -f sim.f -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -q "All tests passed"; then
    exit 0
else
    exit 1
fi
